/* ex_consts.svh */
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// datapath width, fixed by the instruction set
`define EX_XLEN 32

// one quotient bit per iteration
`define EX_DIV_STEPS 32

// wide enough to hold EX_DIV_STEPS itself
`define EX_DIV_CNT_W 6

`endif

/* ex_op_pkg.sv */
`default_nettype none

package ex_op_pkg;

    // execute opcodes
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_SLTU = 4'd9,
        // handled by the divider, not the alu
        OP_DIV  = 4'd10,
        OP_DIVU = 4'd11
    } ex_op_e;

endpackage

`default_nettype wire

/* div_pkg.sv */
`default_nettype none

package div_pkg;

    typedef enum logic [1:0] {
        DIV_IDLE   = 2'b00,
        DIV_BYZERO = 2'b01,
        DIV_ON     = 2'b10,
        DIV_DONE   = 2'b11
    } div_state_e;

endpackage

`default_nettype wire

/* div_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module div_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`EX_XLEN-1:0]    op1_data,
    input  logic [`EX_XLEN-1:0]    op2_data,
    input  logic                   start,
    input  logic                   annul,
    input  logic                   signed_div,
    output logic [2*`EX_XLEN-1:0]  div_result,
    output logic                   div_ready
);
    import div_pkg::*;

    div_state_e                state;
    logic [`EX_DIV_CNT_W-1:0]  cnt;
    // partial remainder above, quotient shifting in below
    logic [2*`EX_XLEN:0]       dividend;
    logic [`EX_XLEN-1:0]       divisor;
    logic [`EX_XLEN-1:0]       abs_op1;
    logic [`EX_XLEN-1:0]       abs_op2;
    logic [`EX_XLEN:0]         div_temp;
    logic                      neg_quot;
    logic                      neg_rem;

    assign abs_op1 = (signed_div && op1_data[`EX_XLEN-1]) ? (~op1_data + 1'b1) : op1_data;
    assign abs_op2 = (signed_div && op2_data[`EX_XLEN-1]) ? (~op2_data + 1'b1) : op2_data;

    // trial subtract, bit 32 set means the divisor did not fit
    assign div_temp = {1'b0, dividend[2*`EX_XLEN-1:`EX_XLEN]} - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= DIV_IDLE;
            div_ready  <= 1'b0;
            div_result <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start && !annul) begin
                        if (op2_data == '0) begin
                            state <= DIV_BYZERO;
                        end else begin
                            state <= DIV_ON;
                        end
                    end else begin
                        div_ready  <= 1'b0;
                        div_result <= '0;
                    end
                end
                DIV_BYZERO: begin
                    state <= DIV_DONE;
                end
                DIV_ON: begin
                    if (annul) begin
                        state <= DIV_IDLE;
                    end else if (cnt == `EX_DIV_STEPS) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: begin
                    div_result <= {dividend[2*`EX_XLEN:`EX_XLEN+1], dividend[`EX_XLEN-1:0]};
                    div_ready  <= 1'b1;
                    // start dropped, back to idle with everything cleared
                    if (!start) begin
                        state      <= DIV_IDLE;
                        div_ready  <= 1'b0;
                        div_result <= '0;
                    end
                end
                default: begin
                    state <= DIV_IDLE;
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        case (state)
            DIV_IDLE: begin
                if (start && !annul && op2_data != '0) begin
                    cnt      <= '0;
                    dividend <= {{`EX_XLEN{1'b0}}, abs_op1, 1'b0};
                    divisor  <= abs_op2;
                    // signs kept here, operands may change later
                    neg_quot <= signed_div && (op1_data[`EX_XLEN-1] ^ op2_data[`EX_XLEN-1]);
                    neg_rem  <= signed_div && op1_data[`EX_XLEN-1];
                end
            end
            DIV_BYZERO: begin
                dividend <= '0;
            end
            DIV_ON: begin
                if (cnt != `EX_DIV_STEPS) begin
                    if (div_temp[`EX_XLEN]) begin
                        dividend <= {dividend[2*`EX_XLEN-1:0], 1'b0};
                    end else begin
                        dividend <= {div_temp[`EX_XLEN-1:0], dividend[`EX_XLEN-1:0], 1'b1};
                    end
                    cnt <= cnt + 1'b1;
                end else begin
                    // sign fixup
                    if (neg_quot) begin
                        dividend[`EX_XLEN-1:0] <= ~dividend[`EX_XLEN-1:0] + 1'b1;
                    end
                    if (neg_rem) begin
                        dividend[2*`EX_XLEN:`EX_XLEN+1] <=
                            ~dividend[2*`EX_XLEN:`EX_XLEN+1] + 1'b1;
                    end
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module alu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid,
    input  ex_op_pkg::ex_op_e    op,
    input  logic [`EX_XLEN-1:0]  src_a,
    input  logic [`EX_XLEN-1:0]  src_b,
    output logic [`EX_XLEN-1:0]  result,
    output logic                 result_valid
);
    import ex_op_pkg::*;

    logic [`EX_XLEN-1:0]  alu_out;
    logic [4:0]           shamt;
    logic                 is_div;

    assign shamt  = src_b[4:0];
    assign is_div = (op == OP_DIV) || (op == OP_DIVU);

    always_comb begin
        case (op)
            OP_ADD:  alu_out = src_a + src_b;
            OP_SUB:  alu_out = src_a - src_b;
            OP_AND:  alu_out = src_a & src_b;
            OP_OR:   alu_out = src_a | src_b;
            OP_XOR:  alu_out = src_a ^ src_b;
            OP_SLL:  alu_out = src_a << shamt;
            OP_SRL:  alu_out = src_a >> shamt;
            OP_SRA:  alu_out = $signed(src_a) >>> shamt;
            OP_SLT: begin
                alu_out = {{(`EX_XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            end
            OP_SLTU: begin
                alu_out = {{(`EX_XLEN-1){1'b0}}, src_a < src_b};
            end
            // divides never reach the result register
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= valid && !is_div;
            if (valid && !is_div) begin
                result <= alu_out;
            end
        end
    end

endmodule

`default_nettype wire

/* ex_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  ex_op_pkg::ex_op_e      op,
    input  logic [`EX_XLEN-1:0]    src_a,
    input  logic [`EX_XLEN-1:0]    src_b,
    input  logic                   flush,
    input  logic [2*`EX_XLEN-1:0]  div_result,
    input  logic                   div_ready,
    output logic                   start,
    output logic                   annul,
    output logic                   signed_div,
    output logic [`EX_XLEN-1:0]    op1,
    output logic [`EX_XLEN-1:0]    op2,
    output logic                   busy,
    output logic                   alu_valid,
    output logic [`EX_XLEN-1:0]    hi,
    output logic [`EX_XLEN-1:0]    lo
);
    import ex_op_pkg::*;

    logic is_div;
    logic accept_div;
    logic div_done;

    assign is_div     = (op == OP_DIV) || (op == OP_DIVU);
    assign alu_valid  = in_valid && !busy && !is_div;
    assign accept_div = in_valid && !busy && is_div;

    // start only falls together with busy, so ready seen here is ours
    assign div_done = busy && start && div_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            start <= 1'b0;
            annul <= 1'b0;
            hi    <= '0;
            lo    <= '0;
        end else begin
            annul <= 1'b0;
            if (accept_div) begin
                busy  <= 1'b1;
                start <= 1'b1;
            end else if (busy && flush) begin
                // cancel, hi/lo keep their old values
                busy  <= 1'b0;
                start <= 1'b0;
                annul <= 1'b1;
            end else if (div_done) begin
                busy  <= 1'b0;
                start <= 1'b0;
                hi    <= div_result[2*`EX_XLEN-1:`EX_XLEN];
                lo    <= div_result[`EX_XLEN-1:0];
            end
        end
    end

    // operands held for the whole divide
    always_ff @(posedge clk) begin
        if (accept_div) begin
            op1        <= src_a;
            op2        <= src_b;
            signed_div <= (op == OP_DIV);
        end
    end

endmodule

`default_nettype wire

/* ex_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  ex_op_pkg::ex_op_e    op,
    input  logic [`EX_XLEN-1:0]  src_a,
    input  logic [`EX_XLEN-1:0]  src_b,
    input  logic                 flush,
    output logic [`EX_XLEN-1:0]  result,
    output logic                 result_valid,
    output logic                 busy,
    output logic [`EX_XLEN-1:0]  hi,
    output logic [`EX_XLEN-1:0]  lo
);

    logic                   alu_valid;
    logic                   start;
    logic                   annul;
    logic                   signed_div;
    logic [`EX_XLEN-1:0]    op1;
    logic [`EX_XLEN-1:0]    op2;
    logic [2*`EX_XLEN-1:0]  div_result;
    logic                   div_ready;

    ex_ctrl u_ex_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .op         (op),
        .src_a      (src_a),
        .src_b      (src_b),
        .flush      (flush),
        .div_result (div_result),
        .div_ready  (div_ready),
        .start      (start),
        .annul      (annul),
        .signed_div (signed_div),
        .op1        (op1),
        .op2        (op2),
        .busy       (busy),
        .alu_valid  (alu_valid),
        .hi         (hi),
        .lo         (lo)
    );

    alu u_alu (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid        (alu_valid),
        .op           (op),
        .src_a        (src_a),
        .src_b        (src_b),
        .result       (result),
        .result_valid (result_valid)
    );

    div_unit u_div_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .op1_data   (op1),
        .op2_data   (op2),
        .start      (start),
        .annul      (annul),
        .signed_div (signed_div),
        .div_result (div_result),
        .div_ready  (div_ready)
    );

endmodule

`default_nettype wire

/* tb_ex_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module tb_ex_top;
    import ex_op_pkg::*;

    localparam int N_EDGE_OPS     = 70;
    localparam int N_RAND_ALU     = 60;
    localparam int N_RAND_DIV     = 20;
    localparam int N_FIXED_DIV    = 13;
    localparam int NUM_OPS        = N_EDGE_OPS + N_RAND_ALU + N_RAND_DIV + N_FIXED_DIV;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + 100;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    ex_op_e                 op;
    logic [`EX_XLEN-1:0]    src_a;
    logic [`EX_XLEN-1:0]    src_b;
    logic                   flush;
    logic [`EX_XLEN-1:0]    result;
    logic                   result_valid;
    logic                   busy;
    logic [`EX_XLEN-1:0]    hi;
    logic [`EX_XLEN-1:0]    lo;

    int                     cycle_cnt = 0;
    int                     mismatch_cnt = 0;
    int                     fail_cnt = 0;
    logic [31:0]            rng_state = 32'h4082;
    logic [63:0]            model_hilo = '0;
    logic                   busy_q = 1'b0;

    // expected values queued by the stimulus for the checker
    logic [31:0]            alu_exp_q[$];
    int                     alu_cyc_q[$];
    logic [63:0]            div_exp_q[$];
    logic [31:0]            chk_res;
    int                     chk_cyc;
    logic [63:0]            chk_hilo;

    ex_op_e                 alu_ops [0:9];
    logic [31:0]            edge_a [0:6];
    logic [31:0]            edge_b [0:6];

    ex_top u_ex_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .op           (op),
        .src_a        (src_a),
        .src_b        (src_b),
        .flush        (flush),
        .result       (result),
        .result_valid (result_valid),
        .busy         (busy),
        .hi           (hi),
        .lo           (lo)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand(output logic [31:0] v);
        rng_state = lcg(rng_state);
        v = rng_state;
    endtask

    // MIPS semantics with the remainder taking the dividend's sign
    function automatic logic [63:0] ref_ex(input ex_op_e o, input logic [31:0] a,
                                           input logic [31:0] b);
        logic [31:0] res;
        logic [31:0] ua;
        logic [31:0] ub;
        logic [31:0] q;
        logic [31:0] r;
        logic        sa;
        logic        sb;
        res = '0;
        case (o)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLL:  res = a << b[4:0];
            OP_SRL:  res = a >> b[4:0];
            OP_SRA:  res = $signed(a) >>> b[4:0];
            OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            OP_DIV, OP_DIVU: begin
                if (b == 32'd0) begin
                    return 64'd0;
                end
                sa = (o == OP_DIV) && a[31];
                sb = (o == OP_DIV) && b[31];
                ua = sa ? (~a + 32'd1) : a;
                ub = sb ? (~b + 32'd1) : b;
                q = ua / ub;
                r = ua % ub;
                if (sa ^ sb) begin
                    q = ~q + 32'd1;
                end
                if (sa) begin
                    r = ~r + 32'd1;
                end
                return {r, q};
            end
            default: res = '0;
        endcase
        return {32'd0, res};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        mismatch_cnt++;
        $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp_v, act_v);
    endtask

    task automatic finish_run();
        $display("mismatches: %0d, other errors: %0d", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    // called on a falling edge with busy low
    task automatic issue_alu(input ex_op_e o, input logic [31:0] a, input logic [31:0] b);
        logic [63:0] r;
        r = ref_ex(o, a, b);
        alu_exp_q.push_back(r[31:0]);
        alu_cyc_q.push_back(cycle_cnt);
        in_valid = 1'b1;
        op = o;
        src_a = a;
        src_b = b;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // flush_after < 0 lets the divide run to the end
    task automatic issue_div(input ex_op_e o, input logic [31:0] a, input logic [31:0] b,
                             input int flush_after, input logic poke_alu);
        logic [63:0] r;
        logic [31:0] junk;
        int          n;
        r = ref_ex(o, a, b);
        if (flush_after < 0) begin
            model_hilo = r;
        end
        div_exp_q.push_back(model_hilo);
        in_valid = 1'b1;
        op = o;
        src_a = a;
        src_b = b;
        @(negedge clk);
        in_valid = 1'b0;
        // operands must be held inside
        src_a = ~a;
        src_b = ~b;
        if (!busy) begin
            fail_cnt++;
            $display("busy did not rise after a divide request at %0t", $time);
        end
        n = 0;
        while (busy) begin
            if (n == flush_after) begin
                flush = 1'b1;
            end
            if (poke_alu && n >= 2 && n < 5) begin
                next_rand(junk);
                in_valid = 1'b1;
                op = OP_XOR;
                src_a = junk;
                src_b = ~junk;
            end else begin
                in_valid = 1'b0;
            end
            @(negedge clk);
            if (flush) begin
                flush = 1'b0;
                if (busy) begin
                    fail_cnt++;
                    $display("busy still high one cycle after flush at %0t", $time);
                end
            end
            n++;
        end
        in_valid = 1'b0;
    endtask

    // compares on a stable falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (result_valid) begin
                if (alu_exp_q.size() == 0) begin
                    fail_cnt++;
                    $display("result_valid pulsed with no ALU op pending at %0t", $time);
                end else begin
                    chk_res = alu_exp_q.pop_front();
                    chk_cyc = alu_cyc_q.pop_front();
                    if (result !== chk_res) begin
                        report_mismatch("result", chk_res, result);
                    end
                    if (cycle_cnt != chk_cyc + 1) begin
                        fail_cnt++;
                        $display("result_valid came %0d cycles after the request at %0t",
                                 cycle_cnt - chk_cyc, $time);
                    end
                end
            end
            if (busy_q && !busy) begin
                if (div_exp_q.size() == 0) begin
                    fail_cnt++;
                    $display("busy fell with no divide pending at %0t", $time);
                end else begin
                    chk_hilo = div_exp_q.pop_front();
                    if (hi !== chk_hilo[63:32]) begin
                        report_mismatch("hi", chk_hilo[63:32], hi);
                    end
                    if (lo !== chk_hilo[31:0]) begin
                        report_mismatch("lo", chk_hilo[31:0], lo);
                    end
                end
            end
            busy_q = busy;
        end
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        fail_cnt++;
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        finish_run();
    end

    initial begin
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] rs;
        rst_n = 1'b0;
        in_valid = 1'b0;
        op = OP_ADD;
        src_a = '0;
        src_b = '0;
        flush = 1'b0;
        alu_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
        edge_a = '{32'h0, 32'hffffffff, 32'h80000000, 32'h80000000,
                   32'h12345678, 32'h80000001, 32'hffffffff};
        edge_b = '{32'h0, 32'hffffffff, 32'h00000001, 32'hffffffff,
                   32'h00000000, 32'h0000001f, 32'h80000000};
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        if (busy !== 1'b0) begin
            report_mismatch("busy", 32'd0, {31'd0, busy});
        end
        if (result_valid !== 1'b0) begin
            report_mismatch("result_valid", 32'd0, {31'd0, result_valid});
        end
        if (hi !== '0) begin
            report_mismatch("hi", 32'd0, hi);
        end
        if (lo !== '0) begin
            report_mismatch("lo", 32'd0, lo);
        end
        if (result !== '0) begin
            report_mismatch("result", 32'd0, result);
        end

        for (int i = 0; i < 7; i++) begin
            for (int k = 0; k < 10; k++) begin
                issue_alu(alu_ops[k], edge_a[i], edge_b[i]);
            end
        end

        for (int i = 0; i < N_RAND_ALU; i++) begin
            next_rand(rs);
            next_rand(ra);
            next_rand(rb);
            issue_alu(alu_ops[rs % 32'd10], ra, rb);
        end

        for (int i = 0; i < N_RAND_DIV; i++) begin
            next_rand(ra);
            next_rand(rb);
            rb = rb >> (i % 24);
            if (rb == 32'd0) begin
                rb = 32'd1;
            end
            issue_div((i % 2 == 1) ? OP_DIV : OP_DIVU, ra, rb, -1, 1'b0);
        end

        // all four sign combinations
        issue_div(OP_DIV, 32'd100, 32'd7, -1, 1'b0);
        issue_div(OP_DIV, -32'sd100, 32'd7, -1, 1'b0);
        issue_div(OP_DIV, 32'd100, -32'sd7, -1, 1'b0);
        issue_div(OP_DIV, -32'sd100, -32'sd7, -1, 1'b0);
        issue_div(OP_DIV, 32'h80000000, 32'd1, -1, 1'b0);
        issue_div(OP_DIVU, 32'h80000000, 32'd1, -1, 1'b0);

        // by zero after a divide that left hi/lo nonzero
        issue_div(OP_DIV, 32'd12345, 32'd0, -1, 1'b0);
        issue_div(OP_DIVU, 32'd77, 32'd5, -1, 1'b0);
        issue_div(OP_DIVU, 32'hffffffff, 32'd0, -1, 1'b0);

        // hi/lo nonzero before the cancel
        issue_div(OP_DIVU, 32'd1000, 32'd3, -1, 1'b0);

        // cancel partway, then a clean divide
        issue_div(OP_DIV, 32'hdeadbeef, 32'd13, 10, 1'b0);
        issue_div(OP_DIVU, 32'hdeadbeef, 32'd13, -1, 1'b0);

        // alu requests while busy are refused
        issue_div(OP_DIV, -32'sd7777777, 32'd321, -1, 1'b1);

        repeat (3) @(negedge clk);
        if (alu_exp_q.size() != 0 || div_exp_q.size() != 0) begin
            fail_cnt++;
            $display("%0d ALU results and %0d divides never completed",
                     alu_exp_q.size(), div_exp_q.size());
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
ex_op_pkg.sv
div_pkg.sv
div_unit.sv
alu.sv
ex_ctrl.sv
ex_top.sv
tb_ex_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
set -u

cd "$(dirname "$0")" || { echo "cannot enter project root"; exit 1; }

verilator --binary --timing -Wno-fatal \
    --top-module tb_ex_top \
    -f list.f \
    -o sim_tb_ex_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb_ex_top 2>&1)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" <<< "$sim_out"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
